//--- design/icache_pkg.sv
`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////
  localparam int WAYS           = 2;
  localparam int PAGE_OFFSET_W  = 12;
  localparam int BLOCK_OFFSET_W = 4;
  localparam int WORD_SEL_W     = 2;

  // Address and data widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // Physical page number, stored as the cache tag
  typedef logic [$bits(addr_t)-PAGE_OFFSET_W-1:0] ptag_t;

  // Four instructions per block
  typedef logic [(1 << BLOCK_OFFSET_W)*8-1:0] block_t;

  typedef logic            way_t;
  typedef logic [WAYS-1:0] ways_t;

  typedef enum logic
  {
    e_ready,
    e_miss
  } cache_state_e;

  //////////////////////////////////////////////////
  // Engine packets
  //////////////////////////////////////////////////
  typedef struct packed
  {
    addr_t addr;
    way_t  way;
  } miss_req_s;

  // Index field is as wide as the page offset allows
  typedef struct packed
  {
    logic [PAGE_OFFSET_W-BLOCK_OFFSET_W-1:0] index;
    way_t                                    way;
    ptag_t                                   tag;
    block_t                                  block;
  } fill_pkt_s;

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////
  typedef struct packed
  {
    addr_t vaddr;
  } tl_stage_s;

  typedef struct packed
  {
    addr_t                 paddr;
    ways_t                 hit_v;
    way_t                  hit_way;
    way_t                  repl_way;
    block_t [WAYS-1:0]     blocks;
  } tv_stage_s;

endpackage

`default_nettype wire

//--- design/icache_decode.sv
`timescale 1ns/10ps
`default_nettype none

module icache_decode
  #(parameter int sets_p = 256,
    localparam int sindex_w = (sets_p > 1) ? $clog2(sets_p) : 1)
  (input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    fetch_v_i,
   input  icache_pkg::addr_t       fetch_vaddr_i,
   output logic                    ready_o,
   input  logic                    req_yumi_i,
   input  logic                    fill_v_i,
   output logic                    rd_v_o,
   output logic [sindex_w-1:0]     rd_index_o,
   output logic                    tl_v_o,
   output icache_pkg::tl_stage_s   tl_o);

  icache_pkg::cache_state_e state_r;
  icache_pkg::cache_state_e state_n;
  logic                     accept;

  assign ready_o = (state_r == icache_pkg::e_ready);
  assign accept  = fetch_v_i & ready_o;

  //////////////////////////////////////////////////
  // Ready / miss FSM
  //////////////////////////////////////////////////
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      icache_pkg::e_ready:
        if (req_yumi_i)
          state_n = icache_pkg::e_miss;
      icache_pkg::e_miss:
        if (fill_v_i)
          state_n = icache_pkg::e_ready;
      default:
        state_n = icache_pkg::e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
    if (reset_i)
      state_r <= icache_pkg::e_ready;
    else
      state_r <= state_n;

  // Array read starts on acceptance
  assign rd_v_o     = accept;
  assign rd_index_o = fetch_vaddr_i[icache_pkg::BLOCK_OFFSET_W +: sindex_w];

  //////////////////////////////////////////////////
  // Lookup stage register
  //////////////////////////////////////////////////
  // A taken request squashes the fetch coming in
  always_ff @(posedge clk_i)
    if (reset_i)
      tl_v_o <= 1'b0;
    else
      tl_v_o <= accept & ~req_yumi_i;

  always_ff @(posedge clk_i)
    if (accept)
      tl_o.vaddr <= fetch_vaddr_i;

endmodule

`default_nettype wire

//--- design/icache_tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_store
  #(parameter int sets_p = 256,
    localparam int sindex_w = (sets_p > 1) ? $clog2(sets_p) : 1)
  (input  logic                                     clk_i,
   input  logic                                     reset_i,
   input  logic                                     rd_v_i,
   input  logic [sindex_w-1:0]                      rd_index_i,
   input  logic                                     fill_v_i,
   input  icache_pkg::fill_pkt_s                    fill_i,
   input  logic                                     lru_v_i,
   input  logic [sindex_w-1:0]                      lru_index_i,
   input  icache_pkg::way_t                         lru_way_i,
   output icache_pkg::ptag_t [icache_pkg::WAYS-1:0] tags_o,
   output icache_pkg::ways_t                        valid_o,
   output icache_pkg::way_t                         lru_o);

  icache_pkg::ptag_t [icache_pkg::WAYS-1:0] tag_mem [sets_p];
  icache_pkg::ways_t [sets_p-1:0]           valid_r;
  icache_pkg::way_t  [sets_p-1:0]           lru_r;
  logic [sindex_w-1:0]                      fill_index;

  assign fill_index = fill_i.index[sindex_w-1:0];

  //////////////////////////////////////////////////
  // Tag array
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
      tag_mem[fill_index][fill_i.way] <= fill_i.tag;
    if (rd_v_i)
      tags_o <= tag_mem[rd_index_i];
  end

  //////////////////////////////////////////////////
  // Valid and LRU bits
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
    if (reset_i)
    begin
      valid_r <= '0;
      lru_r   <= '0;
    end
    else
    begin
      if (fill_v_i)
        valid_r[fill_index][fill_i.way] <= 1'b1;
      if (lru_v_i)
        lru_r[lru_index_i] <= lru_way_i;
    end

  always_ff @(posedge clk_i)
    if (rd_v_i)
    begin
      valid_o <= valid_r[rd_index_i];
      // LRU write landing on the same edge is forwarded
      if (lru_v_i && (lru_index_i == rd_index_i))
        lru_o <= lru_way_i;
      else
        lru_o <= lru_r[rd_index_i];
    end

endmodule

`default_nettype wire

//--- design/icache_data_store.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_store
  #(parameter int sets_p = 256,
    localparam int sindex_w = (sets_p > 1) ? $clog2(sets_p) : 1)
  (input  logic                                      clk_i,
   input  logic                                      rd_v_i,
   input  logic [sindex_w-1:0]                       rd_index_i,
   input  logic                                      fill_v_i,
   input  icache_pkg::fill_pkt_s                     fill_i,
   output icache_pkg::block_t [icache_pkg::WAYS-1:0] blocks_o);

  logic [sindex_w-1:0] fill_index;

  assign fill_index = fill_i.index[sindex_w-1:0];

  //////////////////////////////////////////////////
  // One block array per way
  //////////////////////////////////////////////////
  for (genvar w = 0; w < icache_pkg::WAYS; w++)
  begin : g_way
    icache_pkg::block_t mem [sets_p];
    logic               wr_en;

    // Whole block written by the fill
    assign wr_en = fill_v_i && (fill_i.way == icache_pkg::way_t'(w));

    always_ff @(posedge clk_i)
    begin
      if (wr_en)
        mem[fill_index] <= fill_i.block;
      if (rd_v_i)
        blocks_o[w] <= mem[rd_index_i];
    end
  end

endmodule

`default_nettype wire

//--- design/icache_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module icache_lookup
  #(parameter int sets_p = 256,
    localparam int sindex_w = (sets_p > 1) ? $clog2(sets_p) : 1)
  (input  logic                                      clk_i,
   input  logic                                      reset_i,
   input  logic                                      tl_v_i,
   input  icache_pkg::tl_stage_s                     tl_i,
   input  logic                                      ptag_v_i,
   input  icache_pkg::ptag_t                         ptag_i,
   input  icache_pkg::ptag_t [icache_pkg::WAYS-1:0]  tags_i,
   input  icache_pkg::ways_t                         valid_i,
   input  icache_pkg::way_t                          lru_i,
   input  icache_pkg::block_t [icache_pkg::WAYS-1:0] blocks_i,
   input  logic                                      req_yumi_i,
   output logic                                      tv_v_o,
   output icache_pkg::tv_stage_s                     tv_o);

  icache_pkg::ways_t   hit_v;
  icache_pkg::way_t    hit_way;
  icache_pkg::way_t    lru_cur;
  icache_pkg::way_t    repl_way;
  logic [sindex_w-1:0] tl_index;
  logic [sindex_w-1:0] tv_index;
  logic                same_set;
  logic                tv_we;

  //////////////////////////////////////////////////
  // Tag compare
  //////////////////////////////////////////////////
  // Lowest hitting way wins
  always_comb
  begin
    hit_v   = '0;
    hit_way = 1'b0;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--)
      if (valid_i[w] && (tags_i[w] == ptag_i))
      begin
        hit_v[w] = 1'b1;
        hit_way  = icache_pkg::way_t'(w);
      end
  end

  //////////////////////////////////////////////////
  // Replacement way
  //////////////////////////////////////////////////
  assign tl_index = tl_i.vaddr[icache_pkg::BLOCK_OFFSET_W +: sindex_w];
  assign tv_index = tv_o.paddr[icache_pkg::BLOCK_OFFSET_W +: sindex_w];
  assign same_set = (tl_index == tv_index);

  // Hit in verify stage has not written its LRU bit yet
  assign lru_cur = (tv_v_o && (|tv_o.hit_v) && same_set) ? ~tv_o.hit_way : lru_i;

  // Lowest invalid way first, else LRU
  always_comb
  begin
    repl_way = lru_cur;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--)
      if (!valid_i[w])
        repl_way = icache_pkg::way_t'(w);
  end

  //////////////////////////////////////////////////
  // Verify stage register
  //////////////////////////////////////////////////
  assign tv_we = tl_v_i & ptag_v_i;

  always_ff @(posedge clk_i)
    if (reset_i)
      tv_v_o <= 1'b0;
    else
      tv_v_o <= tv_we & ~req_yumi_i;

  always_ff @(posedge clk_i)
    if (tv_we)
    begin
      tv_o.paddr    <= {ptag_i, tl_i.vaddr[icache_pkg::PAGE_OFFSET_W-1:0]};
      tv_o.hit_v    <= hit_v;
      tv_o.hit_way  <= hit_way;
      tv_o.repl_way <= repl_way;
      tv_o.blocks   <= blocks_i;
    end

endmodule

`default_nettype wire

//--- design/icache_result.sv
`timescale 1ns/10ps
`default_nettype none

module icache_result
  #(parameter int sets_p = 256,
    localparam int sindex_w = (sets_p > 1) ? $clog2(sets_p) : 1)
  (input  logic                  tv_v_i,
   input  icache_pkg::tv_stage_s tv_i,
   output logic                  data_v_o,
   output icache_pkg::instr_t    data_o,
   output logic                  miss_v_o,
   output logic                  req_v_o,
   output icache_pkg::miss_req_s req_o,
   output logic                  lru_v_o,
   output logic [sindex_w-1:0]   lru_index_o,
   output icache_pkg::way_t      lru_way_o);

  localparam int addr_w  = $bits(icache_pkg::addr_t);
  localparam int words_n = 1 << icache_pkg::WORD_SEL_W;

  icache_pkg::instr_t [words_n-1:0]      block_words;
  logic [icache_pkg::WORD_SEL_W-1:0]     word_sel;
  logic                                  hit;

  assign hit = |tv_i.hit_v;

  //////////////////////////////////////////////////
  // Word select
  //////////////////////////////////////////////////
  assign block_words = tv_i.blocks[tv_i.hit_way];

  // Address bits 3:2 pick the instruction
  assign word_sel = tv_i.paddr[icache_pkg::BLOCK_OFFSET_W-1 -: icache_pkg::WORD_SEL_W];

  assign data_o   = block_words[word_sel];
  assign data_v_o = tv_v_i & hit;
  assign miss_v_o = tv_v_i & ~hit;

  //////////////////////////////////////////////////
  // Refill request
  //////////////////////////////////////////////////
  assign req_v_o = miss_v_o;

  // Block-aligned physical address
  assign req_o = '{
    addr: {tv_i.paddr[addr_w-1:icache_pkg::BLOCK_OFFSET_W],
           {icache_pkg::BLOCK_OFFSET_W{1'b0}}},
    way:  tv_i.repl_way
  };

  //////////////////////////////////////////////////
  // LRU update
  //////////////////////////////////////////////////
  // Point away from the way that just hit
  assign lru_v_o     = data_v_o;
  assign lru_index_o = tv_i.paddr[icache_pkg::BLOCK_OFFSET_W +: sindex_w];
  assign lru_way_o   = ~tv_i.hit_way;

endmodule

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top
  #(parameter int sets_p = 256,
    localparam int sindex_w = (sets_p > 1) ? $clog2(sets_p) : 1)
  (input  logic                  clk_i,
   input  logic                  reset_i,
   // Fetch request
   input  logic                  fetch_v_i,
   input  icache_pkg::addr_t     fetch_vaddr_i,
   output logic                  ready_o,
   // Translation, one cycle after acceptance
   input  logic                  ptag_v_i,
   input  icache_pkg::ptag_t     ptag_i,
   // Fetch result
   output logic                  data_v_o,
   output icache_pkg::instr_t    data_o,
   output logic                  miss_v_o,
   // Refill engine
   output logic                  req_v_o,
   output icache_pkg::miss_req_s req_o,
   input  logic                  req_yumi_i,
   input  logic                  fill_v_i,
   input  icache_pkg::fill_pkt_s fill_i);

  logic                                      rd_v;
  logic [sindex_w-1:0]                       rd_index;
  logic                                      tl_v;
  icache_pkg::tl_stage_s                     tl;
  icache_pkg::ptag_t [icache_pkg::WAYS-1:0]  tags;
  icache_pkg::ways_t                         valid;
  icache_pkg::way_t                          lru;
  icache_pkg::block_t [icache_pkg::WAYS-1:0] blocks;
  logic                                      tv_v;
  icache_pkg::tv_stage_s                     tv;
  logic                                      lru_v;
  logic [sindex_w-1:0]                       lru_index;
  icache_pkg::way_t                          lru_way;

  icache_decode #(.sets_p(sets_p)) u_decode
    (.clk_i(clk_i), .reset_i(reset_i),
     .fetch_v_i(fetch_v_i), .fetch_vaddr_i(fetch_vaddr_i), .ready_o(ready_o),
     .req_yumi_i(req_yumi_i), .fill_v_i(fill_v_i),
     .rd_v_o(rd_v), .rd_index_o(rd_index), .tl_v_o(tl_v), .tl_o(tl));

  icache_tag_store #(.sets_p(sets_p)) u_tag_store
    (.clk_i(clk_i), .reset_i(reset_i),
     .rd_v_i(rd_v), .rd_index_i(rd_index),
     .fill_v_i(fill_v_i), .fill_i(fill_i),
     .lru_v_i(lru_v), .lru_index_i(lru_index), .lru_way_i(lru_way),
     .tags_o(tags), .valid_o(valid), .lru_o(lru));

  icache_data_store #(.sets_p(sets_p)) u_data_store
    (.clk_i(clk_i),
     .rd_v_i(rd_v), .rd_index_i(rd_index),
     .fill_v_i(fill_v_i), .fill_i(fill_i),
     .blocks_o(blocks));

  icache_lookup #(.sets_p(sets_p)) u_lookup
    (.clk_i(clk_i), .reset_i(reset_i),
     .tl_v_i(tl_v), .tl_i(tl), .ptag_v_i(ptag_v_i), .ptag_i(ptag_i),
     .tags_i(tags), .valid_i(valid), .lru_i(lru), .blocks_i(blocks),
     .req_yumi_i(req_yumi_i), .tv_v_o(tv_v), .tv_o(tv));

  icache_result #(.sets_p(sets_p)) u_result
    (.tv_v_i(tv_v), .tv_i(tv),
     .data_v_o(data_v_o), .data_o(data_o), .miss_v_o(miss_v_o),
     .req_v_o(req_v_o), .req_o(req_o),
     .lru_v_o(lru_v), .lru_index_o(lru_index), .lru_way_o(lru_way));

endmodule

`default_nettype wire

//--- bench/icache_model.svh
`ifndef ICACHE_MODEL_SVH
`define ICACHE_MODEL_SVH

//////////////////////////////////////////////////
// Cache contents model
//////////////////////////////////////////////////
localparam logic [19:0] xlate_key = 20'h5a3c1;

icache_pkg::ptag_t m_tag   [256][2];
logic [1:0]        m_valid [256];
logic              m_lru   [256];

// Page number flipped by a fixed key
function automatic icache_pkg::addr_t translate(input icache_pkg::addr_t vaddr);
  return {vaddr[31:12] ^ xlate_key, vaddr[11:0]};
endfunction

// Backing memory word, a hash of its aligned address
function automatic icache_pkg::instr_t backing_word(input icache_pkg::addr_t paddr);
  logic [31:0] a;
  a = {paddr[31:2], 2'b00};
  return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
endfunction

function automatic icache_pkg::block_t backing_block(input icache_pkg::addr_t paddr);
  icache_pkg::block_t blk;
  for (int w = 0; w < 4; w++)
    blk[w*32 +: 32] = backing_word({paddr[31:4], 2'(w), 2'b00});
  return blk;
endfunction

task automatic model_clear();
  for (int s = 0; s < 256; s++)
  begin
    m_valid[s] = 2'b00;
    m_lru[s]   = 1'b0;
  end
endtask

task automatic model_fill(input icache_pkg::addr_t paddr, input icache_pkg::way_t way);
  m_tag[paddr[11:4]][way]   = paddr[31:12];
  m_valid[paddr[11:4]][way] = 1'b1;
endtask

// Lowest hitting way wins; a hit points the LRU bit at the other way
task automatic model_lookup(input icache_pkg::addr_t paddr, output logic hit,
                            output icache_pkg::instr_t word, output icache_pkg::way_t repl);
  logic [7:0] set;
  set  = paddr[11:4];
  hit  = 1'b0;
  word = backing_word(paddr);
  repl = m_lru[set];
  for (int w = 1; w >= 0; w--)
    if (!m_valid[set][w])
      repl = 1'(w);
  for (int w = 1; w >= 0; w--)
    if (m_valid[set][w] && (m_tag[set][w] == paddr[31:12]))
    begin
      hit  = 1'b1;
      repl = 1'(w);
    end
  if (hit)
    m_lru[set] = ~repl;
endtask

`endif

//--- bench/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

  localparam int total_cycles = 2800;

  logic                  clk_i;
  logic                  reset_i;
  logic                  fetch_v_i;
  icache_pkg::addr_t     fetch_vaddr_i;
  logic                  ready_o;
  logic                  ptag_v_i;
  icache_pkg::ptag_t     ptag_i;
  logic                  data_v_o;
  icache_pkg::instr_t    data_o;
  logic                  miss_v_o;
  logic                  req_v_o;
  icache_pkg::miss_req_s req_o;
  logic                  req_yumi_i;
  logic                  fill_v_i;
  icache_pkg::fill_pkt_s fill_i;

  icache_top DUT (.*);

  `include "icache_model.svh"

  logic [31:0]       rng = 32'hfe90;
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  // Knobs set by each test
  icache_pkg::addr_t fetch_q [$];
  logic              rand_mode = 1'b0;
  int                yumi_pct = 100;
  int                ptag_pct = 100;
  // Model pipeline and engine
  logic              m_ready = 1'b1;
  logic              tl_v_m = 1'b0;
  icache_pkg::addr_t tl_addr_m = '0;
  logic              exp_data_v = 1'b0;
  logic              exp_miss_v = 1'b0;
  icache_pkg::instr_t exp_data;
  icache_pkg::addr_t exp_req_addr;
  icache_pkg::way_t  exp_req_way;
  icache_pkg::addr_t pend_addr;
  icache_pkg::way_t  pend_way;
  int                fill_wait = 0;
  // Inputs driven in the current cycle
  logic              cur_fetch_v = 1'b0;
  icache_pkg::addr_t cur_vaddr = '0;
  logic              cur_ptag_v = 1'b0;
  logic              cur_yumi = 1'b0;
  logic              cur_fill_v = 1'b0;
  // Seen on the DUT outputs
  int                hits_seen;
  int                misses_seen;
  icache_pkg::addr_t last_req_addr;
  icache_pkg::way_t  last_req_way;

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial
  begin
    #(total_cycles * 40);
    $display("Watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic logic [31:0] rnd();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic chance(input int pct);
    return int'(rnd() % 32'd100) < pct;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////
  // One clock cycle of stimulus and checking
  ////////////////////////////////////////////////////
  task automatic step();
    logic              accept;
    logic              tv_new;
    logic              hit;
    logic              fetch_n;
    logic              fill_n;
    icache_pkg::addr_t tv_paddr;
    icache_pkg::addr_t vaddr_n;
    icache_pkg::addr_t tl_paddr;
    icache_pkg::way_t  repl;
    logic [31:0]       r;
    @(posedge clk_i);
    accept    = cur_fetch_v & m_ready;
    tv_new    = tl_v_m & cur_ptag_v & ~cur_yumi;
    tv_paddr  = translate(tl_addr_m);
    tl_v_m    = accept & ~cur_yumi;
    tl_addr_m = cur_vaddr;
    if (cur_fill_v)
    begin
      model_fill(pend_addr, pend_way);
      m_ready = 1'b1;
    end
    if (cur_yumi)
    begin
      m_ready   = 1'b0;
      pend_addr = exp_req_addr;
      pend_way  = exp_req_way;
      fill_wait = 2 + int'(rnd() % 32'd5);
    end
    exp_data_v = 1'b0;
    exp_miss_v = 1'b0;
    if (tv_new)
    begin
      model_lookup(tv_paddr, hit, exp_data, repl);
      exp_data_v   = hit;
      exp_miss_v   = ~hit;
      exp_req_addr = {tv_paddr[31:4], 4'h0};
      exp_req_way  = repl;
    end
    // Engine takes the request at random and fills later
    cur_yumi = exp_miss_v && chance(yumi_pct);
    fill_n   = 1'b0;
    if (fill_wait > 0)
    begin
      fill_wait--;
      fill_n = (fill_wait == 0);
    end
    cur_fill_v = fill_n;
    // Small address space so sets collide often
    r       = rnd();
    fetch_n = 1'b0;
    vaddr_n = {12'h0, 6'h0, 2'(r[1:0] + 2'd1), 6'h0, r[3:2], r[5:4], 2'b00};
    if (fetch_q.size() != 0 && m_ready)
    begin
      fetch_n = 1'b1;
      vaddr_n = fetch_q.pop_front();
    end
    else if (rand_mode)
      fetch_n = (r[7:6] != 2'b00);
    cur_fetch_v = fetch_n;
    cur_vaddr   = vaddr_n;
    cur_ptag_v  = tl_v_m ? chance(ptag_pct) : r[8];
    tl_paddr    = translate(tl_addr_m);
    fetch_v_i     <= fetch_n;
    fetch_vaddr_i <= vaddr_n;
    ptag_v_i      <= cur_ptag_v;
    ptag_i        <= tl_paddr[31:12];
    req_yumi_i    <= cur_yumi;
    fill_v_i      <= fill_n;
    fill_i        <= '{index: pend_addr[11:4], way: pend_way, tag: pend_addr[31:12],
                       block: backing_block(pend_addr)};
    @(negedge clk_i);
    check("ready_o", 64'(ready_o), 64'(m_ready));
    check("data_v_o", 64'(data_v_o), 64'(exp_data_v));
    check("miss_v_o", 64'(miss_v_o), 64'(exp_miss_v));
    check("req_v_o", 64'(req_v_o), 64'(exp_miss_v));
    if (exp_data_v)
      check("data_o", 64'(data_o), 64'(exp_data));
    if (exp_miss_v)
    begin
      check("req_o.addr", 64'(req_o.addr), 64'(exp_req_addr));
      check("req_o.way", 64'(req_o.way), 64'(exp_req_way));
    end
    hits_seen   += int'(data_v_o);
    misses_seen += int'(miss_v_o);
    if (req_v_o)
    begin
      last_req_addr = req_o.addr;
      last_req_way  = req_o.way;
    end
  endtask

  function automatic logic idle();
    return fetch_q.size() == 0 && !tl_v_m && !exp_data_v && !exp_miss_v && m_ready
           && fill_wait == 0 && !cur_fill_v && !cur_fetch_v && !cur_yumi;
  endfunction

  // Run until the pipeline and engine are quiet
  task automatic settle();
    int n;
    n = 0;
    rand_mode = 1'b0;
    while (!idle() && n < 200)
    begin
      step();
      n++;
    end
    if (!idle())
    begin
      errors++;
      $display("Error: the cache did not go idle within 200 cycles");
    end
  endtask

  task automatic begin_test();
    hits_seen   = 0;
    misses_seen = 0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - errs_before);
  endtask

  initial
  begin
    int e;
    reset_i       <= 1'b1;
    fetch_v_i     <= 1'b0;
    fetch_vaddr_i <= '0;
    ptag_v_i      <= 1'b0;
    ptag_i        <= '0;
    req_yumi_i    <= 1'b0;
    fill_v_i      <= 1'b0;
    fill_i        <= '0;
    model_clear();
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;

    // First fetch misses into way 0
    e = errors;
    begin_test();
    step();
    check("ready_o after reset", 64'(ready_o), 64'd1);
    fetch_q.push_back(32'h0001_0040);
    settle();
    check("misses", 64'(misses_seen), 64'd1);
    check("request address", 64'(last_req_addr), 64'(translate(32'h0001_0040)));
    check("request way", 64'(last_req_way), 64'd0);
    end_test("miss after reset", e);

    // Every word of the filled block hits
    e = errors;
    begin_test();
    for (int w = 0; w < 4; w++)
      fetch_q.push_back(32'h0001_0040 + 32'(w * 4));
    settle();
    check("hits", 64'(hits_seen), 64'd4);
    end_test("refetch hits", e);

    // Second block takes way 1, A hit points LRU at way 1, C evicts B
    e = errors;
    begin_test();
    fetch_q.push_back(32'h0002_0040);
    settle();
    fetch_q.push_back(32'h0001_0044);
    fetch_q.push_back(32'h0003_0048);
    settle();
    check("replacement way", 64'(last_req_way), 64'd1);
    fetch_q.push_back(32'h0002_004c);
    settle();
    check("misses", 64'(misses_seen), 64'd3);
    end_test("replacement", e);

    // Untaken request changes nothing; taken request squashes younger fetches
    e = errors;
    begin_test();
    yumi_pct = 0;
    fetch_q.push_back(32'h0004_0080);
    fetch_q.push_back(32'h0004_0080);
    settle();
    check("ready_o with no yumi", 64'(ready_o), 64'd1);
    check("misses without yumi", 64'(misses_seen), 64'd2);
    begin_test();
    yumi_pct = 100;
    for (int i = 0; i < 3; i++)
      fetch_q.push_back(32'h0004_0084);
    settle();
    check("outputs after squash", 64'(hits_seen + misses_seen), 64'd1);
    end_test("request handshake", e);

    // No translation means no result
    e = errors;
    begin_test();
    ptag_pct = 0;
    fetch_q.push_back(32'h0001_0040);
    fetch_q.push_back(32'h0005_0040);
    settle();
    ptag_pct = 100;
    check("outputs without ptag", 64'(hits_seen + misses_seen), 64'd0);
    end_test("missing translation", e);

    // Long random mix
    e = errors;
    begin_test();
    yumi_pct  = 60;
    ptag_pct  = 90;
    rand_mode = 1'b1;
    repeat (2000) step();
    settle();
    end_test("random mix", e);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+bench
design/icache_pkg.sv
design/icache_decode.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_lookup.sv
design/icache_result.sv
design/icache_top.sv
bench/icache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module icache_tb -f files.f

out=$(./obj_dir/Vicache_tb)
echo "$out"

echo "$out" | grep -q "^PASS: all tests$"
